//--- hdl/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// cache geometry
`define DC_WAYS 2
`define DC_SETS 256
`define DC_WORDS_PER_LINE 4

// pending stores
`define DC_SB_DEPTH 4

// address field bounds
// tag is 31..12, set index 11..4, word index 11..2
`define DC_TAG_LOW 12
`define DC_IDX_LOW 4
`define DC_WORD_LOW 2

`endif

//--- hdl/dcache_pkg.sv
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

    // strb nonzero marks a store
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [1:0]  size;
        logic        is_signed;
    } mem_req_t;

    typedef struct packed {
        logic               hit;
        logic [31:0]        data;
        logic [`DC_WAYS-1:0] way_hit;
        logic               is_store;
    } mem_resp_t;

    typedef struct packed {
        logic                    valid;
        logic [31-`DC_TAG_LOW:0] tag;
    } tag_entry_t;

    // way_hit is captured at lookup time, zero means the store missed
    typedef struct packed {
        logic                     valid;
        logic [31-`DC_WORD_LOW:0] waddr;
        logic [31:0]              data;
        logic [3:0]               strb;
        logic [`DC_WAYS-1:0]      way_hit;
    } sb_entry_t;

    typedef struct packed {
        logic [`DC_TAG_LOW-`DC_WORD_LOW-1:0] waddr;
        logic [31:0]                         data;
        logic [3:0]                          be;
        logic [`DC_WAYS-1:0]                 way;
        logic                                tag_we;
        tag_entry_t                          tag;
    } sram_wr_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        way;
        logic        tag_we;
    } refill_t;

endpackage

`default_nettype wire

//--- hdl/dpsram.sv
`timescale 1ns/100ps
`default_nettype none

module dpsram #(
    parameter type T_ENTRY = logic [31:0],
    parameter int  DEPTH   = 256
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output T_ENTRY                        rd_data_o,
    input  wire logic                     wr_en_i,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  T_ENTRY                        wr_data_i,
    input  wire logic [3:0]               wr_be_i
);

    localparam int W = $bits(T_ENTRY);

    logic [W-1:0] mem [DEPTH];
    logic [W-1:0] rd_q;
    logic [W-1:0] wr_merged;

    // byte lanes only make sense for a plain data word
    if (W == 32) begin : g_bytes
        always_comb begin
            wr_merged = mem[wr_addr_i];
            for (int b = 0; b < 4; b++) begin
                if (wr_be_i[b]) begin
                    wr_merged[8*b +: 8] = wr_data_i[8*b +: 8];
                end
            end
        end
    end else begin : g_whole
        assign wr_merged = (|wr_be_i) ? W'(wr_data_i) : mem[wr_addr_i];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_q <= '0;
        end else begin
            if (wr_en_i) begin
                mem[wr_addr_i] <= wr_merged;
            end
            // same-cycle write to the read address is returned directly
            if (wr_en_i && (wr_addr_i == rd_addr_i)) begin
                rd_q <= wr_merged;
            end else begin
                rd_q <= mem[rd_addr_i];
            end
        end
    end

    assign rd_data_o = T_ENTRY'(rd_q);

    // a write with no byte lanes would waste the shared port
    a_wr_bytes: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_i |-> (|wr_be_i));

endmodule

`default_nettype wire

//--- hdl/store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module store_buffer (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     push_i,
    input  dcache_pkg::sb_entry_t         push_entry_i,
    output logic                          full_o,
    output logic                          empty_o,
    input  wire logic [31-`DC_WORD_LOW:0] fwd_addr_i,
    output logic [31:0]                   fwd_data_o,
    output logic [3:0]                    fwd_mask_o,
    output logic                          drain_valid_o,
    output dcache_pkg::sb_entry_t         drain_entry_o,
    input  wire logic                     drain_grant_i
);

    localparam int PW = $clog2(`DC_SB_DEPTH);

    logic [PW-1:0]           head_q;
    logic [PW-1:0]           tail_q;
    logic [`DC_SB_DEPTH-1:0] vld_q;
    dcache_pkg::sb_entry_t   ent_q [`DC_SB_DEPTH];

    // occupied tail slot means every slot is taken
    assign full_o        = vld_q[tail_q];
    assign empty_o       = !vld_q[head_q];
    assign drain_valid_o = vld_q[head_q];
    assign drain_entry_o = ent_q[head_q];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            vld_q  <= '0;
        end else begin
            if (push_i) begin
                vld_q[tail_q] <= 1'b1;
                tail_q        <= tail_q + 1'b1;
            end
            if (drain_grant_i) begin
                vld_q[head_q] <= 1'b0;
                head_q        <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            ent_q[tail_q] <= push_entry_i;
        end
    end

    // oldest to youngest, so later matches overwrite earlier bytes
    always_comb begin : fwd_scan
        logic [PW-1:0] idx;
        fwd_data_o = '0;
        fwd_mask_o = '0;
        for (int i = 0; i < `DC_SB_DEPTH; i++) begin
            idx = head_q + PW'(i);
            if (vld_q[idx] && ent_q[idx].valid && (ent_q[idx].waddr == fwd_addr_i)) begin
                for (int b = 0; b < 4; b++) begin
                    if (ent_q[idx].strb[b]) begin
                        fwd_data_o[8*b +: 8] = ent_q[idx].data[8*b +: 8];
                        fwd_mask_o[b]        = 1'b1;
                    end
                end
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o);
    a_no_grant_empty: assert property (@(posedge clk) disable iff (!rst_n)
        drain_grant_i |-> !empty_o);

endmodule

`default_nettype wire

//--- hdl/sram_write_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module sram_write_arbiter (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             refill_req_i,
    input  dcache_pkg::refill_t   refill_i,
    output logic                  refill_ack_o,
    input  wire logic             drain_valid_i,
    input  dcache_pkg::sb_entry_t drain_entry_i,
    output logic                  drain_grant_o,
    output logic                  wr_en_o,
    output dcache_pkg::sram_wr_t  wr_o
);

    logic ack_q;
    logic refill_wr;

    // one write per transaction, on the edge where ack rises
    assign refill_wr     = refill_req_i && !ack_q;
    assign drain_grant_o = drain_valid_i && !refill_wr;
    assign refill_ack_o  = ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else if (refill_wr) begin
            ack_q <= 1'b1;
        end else if (!refill_req_i) begin
            ack_q <= 1'b0;
        end
    end

    always_comb begin
        wr_o = '0;
        if (refill_wr) begin
            wr_o.waddr          = refill_i.addr[`DC_TAG_LOW-1:`DC_WORD_LOW];
            wr_o.data           = refill_i.data;
            wr_o.be             = 4'hf;
            wr_o.way[refill_i.way] = 1'b1;
            wr_o.tag_we         = refill_i.tag_we;
            wr_o.tag.valid      = 1'b1;
            wr_o.tag.tag        = refill_i.addr[31:`DC_TAG_LOW];
        end else begin
            wr_o.waddr = drain_entry_i.waddr[`DC_TAG_LOW-`DC_WORD_LOW-1:0];
            wr_o.data  = drain_entry_i.data;
            wr_o.be    = drain_entry_i.strb;
            wr_o.way   = drain_entry_i.way_hit;
        end
    end

    // a missed store pops without a write
    assign wr_en_o = refill_wr || (drain_grant_o && (|drain_entry_i.way_hit));

    a_refill_stable: assert property (@(posedge clk) disable iff (!rst_n)
        refill_req_i && $past(refill_req_i) |-> $stable(refill_i));
    a_one_way: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_o |-> $onehot(wr_o.way));

endmodule

`default_nettype wire

//--- hdl/dcache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_lookup (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                req_valid_i,
    input  dcache_pkg::mem_req_t                     req_i,
    output logic                                     req_ready_o,
    output logic                                     resp_valid_o,
    output dcache_pkg::mem_resp_t                    resp_o,
    input  wire logic                                resp_ready_i,
    output logic [`DC_TAG_LOW-`DC_IDX_LOW-1:0]       rd_idx_o,
    output logic [`DC_TAG_LOW-`DC_WORD_LOW-1:0]      rd_word_o,
    input  dcache_pkg::tag_entry_t [`DC_WAYS-1:0]    tag_rd_i,
    input  wire logic [`DC_WAYS-1:0][31:0]           data_rd_i,
    output logic [31-`DC_WORD_LOW:0]                 fwd_addr_o,
    input  wire logic [31:0]                         fwd_data_i,
    input  wire logic [3:0]                          fwd_mask_i,
    input  wire logic                                sb_full_i,
    output logic                                     sb_push_o,
    output dcache_pkg::sb_entry_t                    sb_entry_o
);

    logic                 stage_vld_q;
    dcache_pkg::mem_req_t stage_q;
    logic                 req_fire;
    logic                 take;
    logic                 is_store;
    logic [31:0]          rd_addr;
    logic [`DC_WAYS-1:0]  tag_hit;
    logic [31:0]          way_data;
    logic [31:0]          merged;
    logic [31:0]          shifted;
    logic [31:0]          load_data;
    logic [3:0]           need;
    logic [3:0]           covered;

    assign is_store  = |stage_q.strb;
    assign take      = stage_vld_q && resp_ready_i;
    assign sb_push_o = take && is_store;

    // a store also needs a free slot that the pushing store does not claim
    assign req_ready_o = (!stage_vld_q || resp_ready_i) &&
                         (!(|req_i.strb) || (!sb_full_i && !sb_push_o));
    assign req_fire    = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_vld_q <= 1'b0;
        end else if (req_fire) begin
            stage_vld_q <= 1'b1;
        end else if (take) begin
            stage_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            stage_q <= req_i;
        end
    end

    // re-read the held address so writes during a stall are seen
    assign rd_addr    = req_fire ? req_i.addr : stage_q.addr;
    assign rd_idx_o   = rd_addr[`DC_TAG_LOW-1:`DC_IDX_LOW];
    assign rd_word_o  = rd_addr[`DC_TAG_LOW-1:`DC_WORD_LOW];
    assign fwd_addr_o = stage_q.addr[31:`DC_WORD_LOW];

    always_comb begin
        tag_hit  = '0;
        way_data = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            tag_hit[w] = tag_rd_i[w].valid && (tag_rd_i[w].tag == stage_q.addr[31:`DC_TAG_LOW]);
            way_data   = way_data | ({32{tag_hit[w]}} & data_rd_i[w]);
        end
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fwd_mask_i[b] ? fwd_data_i[8*b +: 8] : way_data[8*b +: 8];
        end
    end

    // bytes the load actually reads
    always_comb begin
        case (stage_q.size)
            2'd0:    need = 4'b0001 << stage_q.addr[1:0];
            2'd1:    need = 4'b0011 << {stage_q.addr[1], 1'b0};
            default: need = 4'b1111;
        endcase
    end

    assign covered = fwd_mask_i | {4{|tag_hit}};
    assign shifted = merged >> {stage_q.addr[1:0], 3'b000};

    always_comb begin
        case (stage_q.size)
            2'd0: load_data = {{24{stage_q.is_signed & shifted[7]}}, shifted[7:0]};
            2'd1: load_data = {{16{stage_q.is_signed & shifted[15]}}, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    assign resp_valid_o     = stage_vld_q;
    assign resp_o.hit       = is_store ? (|tag_hit) : ((need & ~covered) == 4'b0000);
    assign resp_o.data      = is_store ? 32'h0 : load_data;
    assign resp_o.way_hit   = tag_hit;
    assign resp_o.is_store  = is_store;

    assign sb_entry_o.valid   = 1'b1;
    assign sb_entry_o.waddr   = stage_q.addr[31:`DC_WORD_LOW];
    assign sb_entry_o.data    = stage_q.wdata;
    assign sb_entry_o.strb    = stage_q.strb;
    assign sb_entry_o.way_hit = tag_hit;

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              req_valid_i,
    input  dcache_pkg::mem_req_t   req_i,
    output logic                   req_ready_o,
    output logic                   resp_valid_o,
    output dcache_pkg::mem_resp_t  resp_o,
    input  wire logic              resp_ready_i,
    input  wire logic              refill_req_i,
    input  dcache_pkg::refill_t    refill_i,
    output logic                   refill_ack_o
);

    logic [`DC_TAG_LOW-`DC_IDX_LOW-1:0]    rd_idx;
    logic [`DC_TAG_LOW-`DC_WORD_LOW-1:0]   rd_word;
    dcache_pkg::tag_entry_t [`DC_WAYS-1:0] tag_rd;
    logic [`DC_WAYS-1:0][31:0]             data_rd;
    logic [31-`DC_WORD_LOW:0]              fwd_addr;
    logic [31:0]                           fwd_data;
    logic [3:0]                            fwd_mask;
    logic                                  sb_full;
    logic                                  sb_push;
    dcache_pkg::sb_entry_t                 sb_entry;
    logic                                  drain_valid;
    dcache_pkg::sb_entry_t                 drain_entry;
    logic                                  drain_grant;
    logic                                  wr_en;
    dcache_pkg::sram_wr_t                  wr;

    dcache_lookup u_lookup (
        .clk, .rst_n,
        .req_valid_i, .req_i, .req_ready_o,
        .resp_valid_o, .resp_o, .resp_ready_i,
        .rd_idx_o(rd_idx), .rd_word_o(rd_word),
        .tag_rd_i(tag_rd), .data_rd_i(data_rd),
        .fwd_addr_o(fwd_addr), .fwd_data_i(fwd_data), .fwd_mask_i(fwd_mask),
        .sb_full_i(sb_full), .sb_push_o(sb_push), .sb_entry_o(sb_entry)
    );

    store_buffer u_sb (
        .clk, .rst_n,
        .push_i(sb_push), .push_entry_i(sb_entry),
        .full_o(sb_full), .empty_o(),
        .fwd_addr_i(fwd_addr), .fwd_data_o(fwd_data), .fwd_mask_o(fwd_mask),
        .drain_valid_o(drain_valid), .drain_entry_o(drain_entry),
        .drain_grant_i(drain_grant)
    );

    sram_write_arbiter u_arb (
        .clk, .rst_n,
        .refill_req_i, .refill_i, .refill_ack_o,
        .drain_valid_i(drain_valid), .drain_entry_i(drain_entry),
        .drain_grant_o(drain_grant),
        .wr_en_o(wr_en), .wr_o(wr)
    );

    // set index of the write is the upper part of its word address
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dpsram #(.T_ENTRY(dcache_pkg::tag_entry_t), .DEPTH(`DC_SETS)) u_tag_ram (
            .clk, .rst_n,
            .rd_addr_i(rd_idx), .rd_data_o(tag_rd[w]),
            .wr_en_i(wr_en && wr.way[w] && wr.tag_we),
            .wr_addr_i(wr.waddr[`DC_TAG_LOW-`DC_WORD_LOW-1:`DC_IDX_LOW-`DC_WORD_LOW]),
            .wr_data_i(wr.tag), .wr_be_i(4'hf)
        );

        dpsram #(.T_ENTRY(logic [31:0]), .DEPTH(`DC_SETS * `DC_WORDS_PER_LINE)) u_data_ram (
            .clk, .rst_n,
            .rd_addr_i(rd_word), .rd_data_o(data_rd[w]),
            .wr_en_i(wr_en && wr.way[w]),
            .wr_addr_i(wr.waddr), .wr_data_i(wr.data), .wr_be_i(wr.be)
        );
    end

endmodule

`default_nettype wire

//--- verification/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

    localparam int TIMEOUT = 50;
    localparam int N_STEPS = 29;
    localparam logic [2:0] K_REFILL = 3'd0;
    localparam logic [2:0] K_LOAD   = 3'd1;
    localparam logic [2:0] K_STORE  = 3'd2;
    localparam logic [2:0] K_DRAIN  = 3'd3;
    localparam logic [2:0] K_STALL  = 3'd4;

    // jit 1 picks a random word in the line, jit 2 a random word address
    typedef struct packed {
        logic [2:0]  test;
        logic [2:0]  kind;
        logic [1:0]  jit;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  size;
        logic        sgn;
        logic        way;
        logic        tag_we;
    } step_t;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid_i;
    dcache_pkg::mem_req_t  req_i;
    logic                  req_ready_o;
    logic                  resp_valid_o;
    dcache_pkg::mem_resp_t resp_o;
    logic                  resp_ready_i;
    logic                  refill_req_i;
    dcache_pkg::refill_t   refill_i;
    logic                  refill_ack_o;

    // reference model of refilled lines and committed store bytes
    logic [19:0] m_tag [2][256];
    logic        m_vld [2][256];
    logic [31:0] m_data [2][1024];

    integer seed = 32'h02adcd4b;
    int     err_cnt;
    int     test_err;
    int     chk_cnt;
    int     test_cnt;

    step_t steps [N_STEPS] = '{
        '{3'd1, K_LOAD,   2'd2, 32'h0000_0000, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd1, K_LOAD,   2'd0, 32'h1234_5670, 32'h0, 4'h0, 2'd0, 1'b0, 1'b0, 1'b0},
        '{3'd2, K_REFILL, 2'd0, 32'h1234_5670, 32'h8091_a2b3, 4'h0, 2'd2, 1'b0, 1'b0, 1'b1},
        '{3'd2, K_REFILL, 2'd0, 32'h1234_5674, 32'h1122_3344, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd2, K_REFILL, 2'd0, 32'h1234_5678, 32'hfedc_7f80, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd2, K_REFILL, 2'd0, 32'h1234_567c, 32'h0bad_f00d, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd2, K_LOAD,   2'd0, 32'h1234_5670, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd2, K_LOAD,   2'd0, 32'h1234_5673, 32'h0, 4'h0, 2'd0, 1'b1, 1'b0, 1'b0},
        '{3'd2, K_LOAD,   2'd0, 32'h1234_5673, 32'h0, 4'h0, 2'd0, 1'b0, 1'b0, 1'b0},
        '{3'd2, K_LOAD,   2'd0, 32'h1234_567a, 32'h0, 4'h0, 2'd1, 1'b1, 1'b0, 1'b0},
        '{3'd2, K_LOAD,   2'd0, 32'h1234_5678, 32'h0, 4'h0, 2'd1, 1'b0, 1'b0, 1'b0},
        '{3'd2, K_LOAD,   2'd1, 32'h1234_5674, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd3, K_REFILL, 2'd0, 32'habcd_e670, 32'hcafe_0001, 4'h0, 2'd2, 1'b0, 1'b1, 1'b1},
        '{3'd3, K_REFILL, 2'd0, 32'habcd_e674, 32'h5555_aaaa, 4'h0, 2'd2, 1'b0, 1'b1, 1'b0},
        '{3'd3, K_REFILL, 2'd0, 32'habcd_e678, 32'h0000_ff00, 4'h0, 2'd2, 1'b0, 1'b1, 1'b0},
        '{3'd3, K_REFILL, 2'd0, 32'habcd_e67c, 32'h7e7e_8181, 4'h0, 2'd2, 1'b0, 1'b1, 1'b0},
        '{3'd3, K_LOAD,   2'd0, 32'habcd_e674, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd3, K_LOAD,   2'd1, 32'h1234_567c, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd3, K_LOAD,   2'd1, 32'habcd_e670, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd3, K_LOAD,   2'd0, 32'h0000_1670, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd4, K_STORE,  2'd0, 32'h1234_5674, 32'hdead_beef, 4'h6, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd4, K_LOAD,   2'd0, 32'h1234_5674, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd4, K_LOAD,   2'd0, 32'h1234_5675, 32'h0, 4'h0, 2'd0, 1'b1, 1'b0, 1'b0},
        '{3'd4, K_DRAIN,  2'd0, 32'h0000_0000, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd4, K_LOAD,   2'd0, 32'h1234_5674, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd5, K_STALL,  2'd0, 32'habcd_e678, 32'h0, 4'h0, 2'd1, 1'b1, 1'b0, 1'b0},
        '{3'd6, K_STORE,  2'd0, 32'h0000_2670, 32'h1234_5678, 4'hf, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd6, K_DRAIN,  2'd0, 32'h0000_0000, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{3'd6, K_LOAD,   2'd0, 32'h0000_2670, 32'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0}
    };

    dcache_top UUT (
        .clk, .rst_n,
        .req_valid_i, .req_i, .req_ready_o,
        .resp_valid_o, .resp_o, .resp_ready_i,
        .refill_req_i, .refill_i, .refill_ack_o
    );

    always #4 clk = ~clk;

    function automatic logic [1:0] way_hits(input logic [31:0] a);
        logic [1:0] h;
        for (int w = 0; w < 2; w++) begin
            h[w] = m_vld[w][a[11:4]] && (m_tag[w][a[11:4]] == a[31:12]);
        end
        return h;
    endfunction

    // pick the addressed bytes, then sign or zero extend
    function automatic logic [31:0] extend(input logic [31:0] word, input logic [1:0] boff,
                                           input logic [1:0] size, input logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*boff +: 8];
        h = word[16*boff[1] +: 16];
        if (size == 2'd0) begin
            return sgn ? {{24{b[7]}}, b} : {24'h0, b};
        end else if (size == 2'd1) begin
            return sgn ? {{16{h[15]}}, h} : {16'h0, h};
        end
        return word;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
        chk_cnt++;
        assert (got === exp) else begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic timed_out(input string what);
        $display("ERROR: timed out waiting for %s", what);
        err_cnt++;
        test_err++;
    endtask

    // four-phase refill of one word, starts and ends on a falling edge
    task automatic do_refill(input step_t s);
        int n;
        refill_i.addr   = s.addr;
        refill_i.data   = s.data;
        refill_i.way    = s.way;
        refill_i.tag_we = s.tag_we;
        refill_req_i    = 1'b1;
        n = 0;
        @(negedge clk);
        while (!refill_ack_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!refill_ack_o) timed_out("refill ack to rise");
        refill_req_i = 1'b0;
        n = 0;
        @(negedge clk);
        while (refill_ack_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (refill_ack_o) timed_out("refill ack to fall");
        if (s.tag_we) begin
            m_tag[s.way][s.addr[11:4]] = s.addr[31:12];
            m_vld[s.way][s.addr[11:4]] = 1'b1;
        end
        m_data[s.way][s.addr[11:2]] = s.data;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (!UUT.u_sb.empty_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!UUT.u_sb.empty_o) timed_out("store buffer to drain");
    endtask

    // returns on the falling edge where the response is first visible
    task automatic cpu_access(input step_t s, input logic [31:0] addr, input int hold,
                              output dcache_pkg::mem_resp_t got);
        int n;
        req_i.addr      = addr;
        req_i.wdata     = s.data;
        req_i.strb      = s.strb;
        req_i.size      = s.size;
        req_i.is_signed = s.sgn;
        req_valid_i     = 1'b1;
        n = 0;
        #1;
        while (!req_ready_o && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!req_ready_o) timed_out("req_ready_o");
        @(negedge clk);
        req_valid_i = 1'b0;
        // the previous response has been taken, now hold this one
        if (hold > 0) resp_ready_i = 1'b0;
        n = 0;
        while (!resp_valid_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!resp_valid_o) timed_out("resp_valid_o");
        got = resp_o;
        for (int h = 0; h < hold; h++) begin
            @(negedge clk);
            #1;
            check("req_ready_o", 64'(1'b0), 64'(req_ready_o));
            check("resp_valid_o", 64'(1'b1), 64'(resp_valid_o));
            check("resp_o", 64'(got), 64'(resp_o));
        end
        if (hold > 0) begin
            @(negedge clk);
            resp_ready_i = 1'b1;
            @(negedge clk);
            check("resp_valid_o", 64'(1'b0), 64'(resp_valid_o));
        end
    endtask

    task automatic report_test(input int t);
        test_cnt++;
        $display("test %0d: %s (%0d errors)", t, (test_err == 0) ? "ok" : "failed", test_err);
    endtask

    initial begin
        step_t                 s;
        logic [31:0]           addr;
        logic [31:0]           rnd;
        logic [1:0]            hits;
        dcache_pkg::mem_resp_t got;
        int                    cur;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b1;
        refill_req_i = 1'b0;
        refill_i     = '0;
        err_cnt      = 0;
        chk_cnt      = 0;
        test_cnt     = 0;
        for (int w = 0; w < 2; w++) begin
            for (int i = 0; i < 256; i++) begin
                m_vld[w][i] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        cur      = 1;
        test_err = 0;
        check("resp_valid_o", 64'(1'b0), 64'(resp_valid_o));
        check("refill_ack_o", 64'(1'b0), 64'(refill_ack_o));

        for (int i = 0; i < N_STEPS; i++) begin
            s = steps[i];
            if (int'(s.test) != cur) begin
                report_test(cur);
                cur      = int'(s.test);
                test_err = 0;
            end
            rnd  = $random(seed);
            addr = s.addr;
            if (s.jit == 2'd1) addr[3:2] = rnd[1:0];
            if (s.jit == 2'd2) addr = {rnd[31:2], 2'b00};
            case (s.kind)
                K_REFILL: do_refill(s);
                K_DRAIN:  wait_drain();
                default: begin
                    hits = way_hits(addr);
                    cpu_access(s, addr, (s.kind == K_STALL) ? 3 : 0, got);
                    check("resp_o.way_hit", 64'(hits), 64'(got.way_hit));
                    check("resp_o.hit", 64'(|hits), 64'(got.hit));
                    check("resp_o.is_store", 64'(s.kind == K_STORE), 64'(got.is_store));
                    if (s.kind != K_STORE && (|hits)) begin
                        check("resp_o.data",
                              64'(extend(m_data[hits[1]][addr[11:2]], addr[1:0], s.size, s.sgn)),
                              64'(got.data));
                    end
                    // a missed store never reaches the SRAM
                    if (s.kind == K_STORE && (|hits)) begin
                        for (int b = 0; b < 4; b++) begin
                            if (s.strb[b]) begin
                                m_data[hits[1]][addr[11:2]][8*b +: 8] = s.data[8*b +: 8];
                            end
                        end
                    end
                end
            endcase
        end
        report_test(cur);

        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dpsram.sv
hdl/store_buffer.sv
hdl/sram_write_arbiter.sv
hdl/dcache_lookup.sv
hdl/dcache_top.sv
verification/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module dcache_tb -f files.f -o Vdcache_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vdcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "result: failed"
    exit 1
fi
echo "result: passed"
exit 0
